//--- aes_dec_pkg.sv
package aes_dec_pkg;

    typedef logic [127:0] block_t;
    typedef logic [127:0] key_t;
    typedef logic [31:0]  word_t;
    typedef logic [7:0]   byte_t;
    typedef logic [3:0]   round_idx_t;

    localparam int NUM_ROUNDS   = 10;
    localparam int NUM_KEYS     = 11;
    localparam int PIPE_LATENCY = 10;  // one registered stage per round
    localparam int KEY_LATENCY  = 11;  // load edge to ready flag visible

    // ----------------------------------------
    // substitution tables

    // entry 0x00 sits in the top byte, 0xff in the bottom byte
    localparam logic [2047:0] SBOX_TBL = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    localparam logic [2047:0] INV_SBOX_TBL = {
        128'h52096ad53036a538bf40a39e81f3d7fb,
        128'h7ce339829b2fff87348e4344c4dee9cb,
        128'h547b9432a6c2233dee4c950b42fac34e,
        128'h082ea16628d924b2765ba2496d8bd125,
        128'h72f8f66486689816d4a45ccc5d65b692,
        128'h6c704850fdedb9da5e154657a78d9d84,
        128'h90d8ab008cbcd30af7e45805b8b34506,
        128'hd02c1e8fca3f0f02c1afbd0301138a6b,
        128'h3a9111414f67dcea97f2cfcef0b4e673,
        128'h96ac7422e7ad3585e2f937e81c75df6e,
        128'h47f11a711d29c5896fb7620eaa18be1b,
        128'hfc563e4bc6d279209adbc0fe78cd5af4,
        128'h1fdda8338807c731b11210592780ec5f,
        128'h60517fa919b54a0d2de57a9f93c99cef,
        128'ha0e03b4dae2af5b0c8ebbb3c83539961,
        128'h172b047eba77d626e169146355210c7d
    };

    function automatic byte_t sbox(input byte_t x);
        return SBOX_TBL[(255 - int'(x)) * 8 +: 8];
    endfunction

    function automatic byte_t inv_sbox(input byte_t x);
        return INV_SBOX_TBL[(255 - int'(x)) * 8 +: 8];
    endfunction

    function automatic byte_t rcon(input round_idx_t idx);
        case (idx)
            4'd1:    return 8'h01;
            4'd2:    return 8'h02;
            4'd3:    return 8'h04;
            4'd4:    return 8'h08;
            4'd5:    return 8'h10;
            4'd6:    return 8'h20;
            4'd7:    return 8'h40;
            4'd8:    return 8'h80;
            4'd9:    return 8'h1b;
            4'd10:   return 8'h36;
            default: return 8'h00;
        endcase
    endfunction

    // ----------------------------------------
    // GF(2^8) arithmetic, polynomial x^8 + x^4 + x^3 + x + 1

    function automatic byte_t xtime(input byte_t x);
        return {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic byte_t gmul(input byte_t a, input byte_t b);
        byte_t acc;
        byte_t p;
        acc = '0;
        p   = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) acc = acc ^ p;
            p = xtime(p);
        end
        return acc;
    endfunction

    // ----------------------------------------
    // whole-block transforms, byte k of the state at bits [127-8k -: 8]

    function automatic block_t inv_shift_rows(input block_t s);
        block_t o;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                o[127 - 8 * (4 * c + r) -: 8] = s[127 - 8 * (4 * ((c - r + 4) % 4) + r) -: 8];
            end
        end
        return o;
    endfunction

    function automatic block_t inv_sub_bytes(input block_t s);
        block_t o;
        for (int k = 0; k < 16; k++) begin
            o[127 - 8 * k -: 8] = inv_sbox(s[127 - 8 * k -: 8]);
        end
        return o;
    endfunction

    function automatic block_t inv_mix_columns(input block_t s);
        block_t o;
        word_t  col;
        for (int c = 0; c < 4; c++) begin
            col = s[127 - 32 * c -: 32];
            o[127 - 32 * c -: 8] = gmul(col[31:24], 8'h0e) ^ gmul(col[23:16], 8'h0b)
                                 ^ gmul(col[15:8], 8'h0d) ^ gmul(col[7:0], 8'h09);
            o[119 - 32 * c -: 8] = gmul(col[31:24], 8'h09) ^ gmul(col[23:16], 8'h0e)
                                 ^ gmul(col[15:8], 8'h0b) ^ gmul(col[7:0], 8'h0d);
            o[111 - 32 * c -: 8] = gmul(col[31:24], 8'h0d) ^ gmul(col[23:16], 8'h09)
                                 ^ gmul(col[15:8], 8'h0e) ^ gmul(col[7:0], 8'h0b);
            o[103 - 32 * c -: 8] = gmul(col[31:24], 8'h0b) ^ gmul(col[23:16], 8'h0d)
                                 ^ gmul(col[15:8], 8'h09) ^ gmul(col[7:0], 8'h0e);
        end
        return o;
    endfunction

endpackage

//--- key_sched_if.sv
`timescale 1ns/1ps

interface key_sched_if;

    logic                    wr_en;
    aes_dec_pkg::round_idx_t wr_idx;
    aes_dec_pkg::key_t       wr_key;
    logic                    clear;   // pulses with the key load
    logic                    ready;   // all eleven round keys held

    modport expander (
        output wr_en,
        output wr_idx,
        output wr_key,
        output clear
    );

    modport store (
        input  wr_en,
        input  wr_idx,
        input  wr_key,
        input  clear,
        output ready
    );

endinterface

//--- key_expander.sv
`timescale 1ns/1ps

module key_expander (
    input  logic              clk,
    input  logic              rst,
    input  logic              key_load,
    input  aes_dec_pkg::key_t key,
    key_sched_if.expander     kx
);

    typedef enum logic [1:0] {
        IDLE,
        EXPAND,
        DONE
    } kx_state_t;

    kx_state_t               state;
    aes_dec_pkg::round_idx_t idx;       // index of the key derived this cycle
    aes_dec_pkg::key_t       prev_key;  // round key written on the previous cycle
    aes_dec_pkg::key_t       next_key;
    aes_dec_pkg::word_t      temp;
    aes_dec_pkg::word_t      n0;
    aes_dec_pkg::word_t      n1;
    aes_dec_pkg::word_t      n2;
    aes_dec_pkg::word_t      n3;

    // ----------------------------------------
    // forward schedule, RotWord then SubWord on the last word
    always_comb begin
        temp = {aes_dec_pkg::sbox(prev_key[23:16]),
                aes_dec_pkg::sbox(prev_key[15:8]),
                aes_dec_pkg::sbox(prev_key[7:0]),
                aes_dec_pkg::sbox(prev_key[31:24])};
        temp[31:24] = temp[31:24] ^ aes_dec_pkg::rcon(idx);
        n0 = prev_key[127:96] ^ temp;
        n1 = prev_key[95:64] ^ n0;
        n2 = prev_key[63:32] ^ n1;
        n3 = prev_key[31:0] ^ n2;
        next_key = {n0, n1, n2, n3};
    end

    // key 0 goes straight to the store on the load edge
    always_comb begin
        kx.clear  = key_load;
        kx.wr_en  = key_load || (state == EXPAND);
        kx.wr_idx = key_load ? '0 : idx;
        kx.wr_key = key_load ? key : next_key;
    end

    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= IDLE;
            idx   <= '0;
        end else if (key_load) begin
            state <= EXPAND;  // a load mid-expansion restarts from key 0
            idx   <= aes_dec_pkg::round_idx_t'(1);
        end else if (state == EXPAND) begin
            if (idx == aes_dec_pkg::round_idx_t'(aes_dec_pkg::NUM_ROUNDS)) begin
                state <= DONE;
            end else begin
                idx <= idx + aes_dec_pkg::round_idx_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (key_load) begin
            prev_key <= key;
        end else if (state == EXPAND) begin
            prev_key <= next_key;
        end
    end

endmodule

//--- round_key_store.sv
`timescale 1ns/1ps

module round_key_store (
    input  logic              clk,
    input  logic              rst,
    key_sched_if.store        kx,
    output aes_dec_pkg::key_t rk0,
    output aes_dec_pkg::key_t rk1,
    output aes_dec_pkg::key_t rk2,
    output aes_dec_pkg::key_t rk3,
    output aes_dec_pkg::key_t rk4,
    output aes_dec_pkg::key_t rk5,
    output aes_dec_pkg::key_t rk6,
    output aes_dec_pkg::key_t rk7,
    output aes_dec_pkg::key_t rk8,
    output aes_dec_pkg::key_t rk9,
    output aes_dec_pkg::key_t rk10
);

    aes_dec_pkg::key_t keys [aes_dec_pkg::NUM_KEYS];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < aes_dec_pkg::NUM_KEYS; i++) begin
                keys[i] <= '0;
            end
        end else begin
            for (int i = 0; i < aes_dec_pkg::NUM_KEYS; i++) begin
                if (kx.wr_en && kx.wr_idx == aes_dec_pkg::round_idx_t'(i)) keys[i] <= kx.wr_key;
            end
        end
    end

    // clear wins over a late write of the last key
    always_ff @(posedge clk) begin
        if (!rst || kx.clear) begin
            kx.ready <= 1'b0;
        end else if (kx.wr_en && kx.wr_idx == aes_dec_pkg::round_idx_t'(aes_dec_pkg::NUM_ROUNDS)) begin
            kx.ready <= 1'b1;
        end
    end

    assign rk0  = keys[0];
    assign rk1  = keys[1];
    assign rk2  = keys[2];
    assign rk3  = keys[3];
    assign rk4  = keys[4];
    assign rk5  = keys[5];
    assign rk6  = keys[6];
    assign rk7  = keys[7];
    assign rk8  = keys[8];
    assign rk9  = keys[9];
    assign rk10 = keys[10];

endmodule

//--- inv_round_entry.sv
`timescale 1ns/1ps

module inv_round_entry (
    input  logic                clk,
    input  logic                rst,
    input  aes_dec_pkg::block_t state_in,
    input  aes_dec_pkg::key_t   round_key,
    output aes_dec_pkg::block_t state_out
);

    aes_dec_pkg::block_t added;
    aes_dec_pkg::block_t round_res;

    // no InvMixColumns in the first inverse round
    assign added     = state_in ^ round_key;
    assign round_res = aes_dec_pkg::inv_sub_bytes(aes_dec_pkg::inv_shift_rows(added));

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_out <= '0;
        end else begin
            state_out <= round_res;
        end
    end

endmodule

//--- inv_round_mid.sv
`timescale 1ns/1ps

module inv_round_mid (
    input  logic                clk,
    input  logic                rst,
    input  aes_dec_pkg::block_t state_in,
    input  aes_dec_pkg::key_t   round_key,
    output aes_dec_pkg::block_t state_out
);

    aes_dec_pkg::block_t added;
    aes_dec_pkg::block_t mixed;
    aes_dec_pkg::block_t round_res;

    // key add of this round, then the row and byte steps of the next one
    assign added     = state_in ^ round_key;
    assign mixed     = aes_dec_pkg::inv_mix_columns(added);
    assign round_res = aes_dec_pkg::inv_sub_bytes(aes_dec_pkg::inv_shift_rows(mixed));

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_out <= '0;
        end else begin
            state_out <= round_res;
        end
    end

endmodule

//--- inv_round_final.sv
`timescale 1ns/1ps

module inv_round_final (
    input  logic                clk,
    input  logic                rst,
    input  aes_dec_pkg::block_t state_in,
    input  aes_dec_pkg::key_t   round_key,
    input  aes_dec_pkg::key_t   last_key,
    output aes_dec_pkg::block_t state_out
);

    aes_dec_pkg::block_t added;
    aes_dec_pkg::block_t mixed;
    aes_dec_pkg::block_t subbed;
    aes_dec_pkg::block_t plain;

    assign added  = state_in ^ round_key;
    assign mixed  = aes_dec_pkg::inv_mix_columns(added);
    assign subbed = aes_dec_pkg::inv_sub_bytes(aes_dec_pkg::inv_shift_rows(mixed));

    // cipher key whitening undone last
    assign plain  = subbed ^ last_key;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_out <= '0;
        end else begin
            state_out <= plain;
        end
    end

endmodule

//--- aes_dec_pipe.sv
`timescale 1ns/1ps

module aes_dec_pipe (
    input  logic                clk,
    input  logic                rst,
    input  logic                key_load,
    input  aes_dec_pkg::key_t   key,
    input  logic                in_valid,
    input  aes_dec_pkg::block_t in_block,
    output logic                key_ready,
    output logic                out_valid,
    output aes_dec_pkg::block_t out_block
);

    aes_dec_pkg::key_t   rk [aes_dec_pkg::NUM_KEYS];
    aes_dec_pkg::block_t st [1:aes_dec_pkg::NUM_ROUNDS];   // st[n] is the output of stage n
    logic [aes_dec_pkg::PIPE_LATENCY-1:0] vld_sr;

    key_sched_if kx ();

    // ----------------------------------------
    // key path
    key_expander u_key_expander (
        .clk      (clk),
        .rst      (rst),
        .key_load (key_load),
        .key      (key),
        .kx       (kx.expander)
    );

    round_key_store u_round_key_store (
        .clk  (clk),
        .rst  (rst),
        .kx   (kx.store),
        .rk0  (rk[0]),
        .rk1  (rk[1]),
        .rk2  (rk[2]),
        .rk3  (rk[3]),
        .rk4  (rk[4]),
        .rk5  (rk[5]),
        .rk6  (rk[6]),
        .rk7  (rk[7]),
        .rk8  (rk[8]),
        .rk9  (rk[9]),
        .rk10 (rk[10])
    );

    assign key_ready = kx.ready;

    // ----------------------------------------
    // round stages, keys consumed from 10 down to 0
    inv_round_entry u_round_entry (
        .clk       (clk),
        .rst       (rst),
        .state_in  (in_block),
        .round_key (rk[10]),
        .state_out (st[1])
    );

    for (genvar g = 0; g < 8; g++) begin : g_mid
        inv_round_mid u_round_mid (
            .clk       (clk),
            .rst       (rst),
            .state_in  (st[g + 1]),
            .round_key (rk[9 - g]),
            .state_out (st[g + 2])
        );
    end

    inv_round_final u_round_final (
        .clk       (clk),
        .rst       (rst),
        .state_in  (st[9]),
        .round_key (rk[1]),
        .last_key  (rk[0]),
        .state_out (st[10])
    );

    // ----------------------------------------
    // valid travels beside the data, one bit per stage
    always_ff @(posedge clk) begin
        if (!rst) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[aes_dec_pkg::PIPE_LATENCY-2:0], in_valid};
        end
    end

    assign out_valid = vld_sr[aes_dec_pkg::PIPE_LATENCY-1];
    assign out_block = out_valid ? st[aes_dec_pkg::NUM_ROUNDS] : '0;

endmodule

//--- aes_dec_pipe_chk.sv
`timescale 1ns/1ps

module aes_dec_pipe_chk (
    input logic                clk,
    input logic                rst,
    input logic                key_load,
    input logic                in_valid,
    input logic                key_ready,
    input logic                out_valid,
    input aes_dec_pkg::block_t out_block
);

    int fail_count = 0;
    int warm_cnt;   // rising edges since reset, saturating
    int load_age;   // edges since the last sampled key load, 0 when none

    always_ff @(posedge clk) begin
        if (!rst) begin
            warm_cnt <= 0;
            load_age <= 0;
        end else begin
            if (warm_cnt < aes_dec_pkg::PIPE_LATENCY) warm_cnt <= warm_cnt + 1;
            if (key_load) load_age <= 1;
            else if (load_age != 0 && load_age < 15) load_age <= load_age + 1;
        end
    end

    // ----------------------------------------
    valid_delay: assert property (@(posedge clk) disable iff (!rst)
        (warm_cnt >= aes_dec_pkg::PIPE_LATENCY)
            |-> (out_valid == $past(in_valid, aes_dec_pkg::PIPE_LATENCY)))
        else begin fail_count++; $error("out_valid does not follow in_valid by ten cycles"); end

    out_gated: assert property (@(posedge clk) disable iff (!rst)
        !out_valid |-> (out_block == '0))
        else begin fail_count++; $error("out_block is not zero while out_valid is low"); end

    ready_drop: assert property (@(posedge clk) disable iff (!rst)
        key_load |=> !key_ready)
        else begin fail_count++; $error("key_ready stayed high after a key load"); end

    ready_rise: assert property (@(posedge clk) disable iff (!rst)
        (load_age == aes_dec_pkg::KEY_LATENCY) |-> key_ready)
        else begin fail_count++; $error("key_ready not high after key expansion"); end

endmodule

bind aes_dec_pipe aes_dec_pipe_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .key_load  (key_load),
    .in_valid  (in_valid),
    .key_ready (key_ready),
    .out_valid (out_valid),
    .out_block (out_block)
);

//--- tb_aes_dec_pipe.sv
`timescale 1ns/1ps

module tb_aes_dec_pipe;

    localparam int          NUM_VEC        = 5;
    localparam int          TIMEOUT_CYCLES = NUM_VEC * 40 + 200;
    localparam int          PL             = aes_dec_pkg::PIPE_LATENCY;
    localparam int unsigned SEED           = 32'h9861a039;

    logic                clk;
    logic                rst;
    logic                key_load;
    aes_dec_pkg::key_t   key;
    logic                in_valid;
    aes_dec_pkg::block_t in_block;
    logic                key_ready;
    logic                out_valid;
    aes_dec_pkg::block_t out_block;

    aes_dec_pkg::block_t exp_q [$];             // plaintexts of blocks in flight
    logic [PL-1:0]       vld_hist = '0;         // in_valid as sampled at each rising edge
    int                  cycles   = 0;

    // ----------------------------------------
    // the FIPS-197 C.1 vector then the SP 800-38A ECB-AES128 vectors
    aes_dec_pkg::key_t tbl_key [NUM_VEC] = '{
        128'h000102030405060708090a0b0c0d0e0f,
        128'h2b7e151628aed2a6abf7158809cf4f3c,
        128'h2b7e151628aed2a6abf7158809cf4f3c,
        128'h2b7e151628aed2a6abf7158809cf4f3c,
        128'h2b7e151628aed2a6abf7158809cf4f3c
    };
    aes_dec_pkg::block_t tbl_ct [NUM_VEC] = '{
        128'h69c4e0d86a7b0430d8cdb78070b4c55a,
        128'h3ad77bb40d7a3660a89ecaf32466ef97,
        128'hf5d3d58503b9699de785895a96fdbaaf,
        128'h43b1cd7f598ece23881b00e3ed030688,
        128'h7b0c785e27e8ad3f8223207104725dd4
    };
    aes_dec_pkg::block_t tbl_pt [NUM_VEC] = '{
        128'h00112233445566778899aabbccddeeff,
        128'h6bc1bee22e409f96e93d7e117393172a,
        128'hae2d8a571e03ac9c9eb76fac45af8e51,
        128'h30c81c46a35ce411e5fbc1191a0a52ef,
        128'hf69f2445df4f9b17ad2b417be66c3710
    };

    aes_dec_pipe dut (
        .clk       (clk),
        .rst       (rst),
        .key_load  (key_load),
        .key       (key),
        .in_valid  (in_valid),
        .in_block  (in_block),
        .key_ready (key_ready),
        .out_valid (out_valid),
        .out_block (out_block)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // checks

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_block(input string name, input aes_dec_pkg::block_t got,
                               input aes_dec_pkg::block_t exp);
        if (got !== exp) fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) fail_now("timeout: the run did not finish in time");
        if (!rst) vld_hist <= '0;
        else vld_hist <= {vld_hist[PL-2:0], in_valid};
    end

    always @(negedge clk) begin
        if (dut.u_chk.fail_count != 0) fail_now("an assertion in the checker failed");
        check_bit("out_valid", out_valid, vld_hist[PL-1]);
        if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) fail_now("an output block appeared with none in flight");
            else check_block("out_block", out_block, exp_q.pop_front());
        end else begin
            check_block("out_block", out_block, '0);  // gating while not valid
        end
    end

    // ----------------------------------------
    // stimulus

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
            in_block = {$urandom, $urandom, $urandom, $urandom};  // junk must not leak out
        end
    endtask

    task automatic send_block(input aes_dec_pkg::block_t ct, input aes_dec_pkg::block_t pt);
        @(negedge clk);
        in_valid = 1'b1;
        in_block = ct;
        exp_q.push_back(pt);
    endtask

    task automatic load_key(input aes_dec_pkg::key_t k);
        int n;
        @(negedge clk);
        key_load = 1'b1;
        key      = k;
        @(negedge clk);
        key_load = 1'b0;
        n        = 1;
        check_bit("key_ready", key_ready, 1'b0);  // drops right after the load
        while (key_ready !== 1'b1 && n < 2 * aes_dec_pkg::KEY_LATENCY) begin
            @(negedge clk);
            n++;
        end
        check_count("key_ready latency", n, aes_dec_pkg::KEY_LATENCY);
    endtask

    task automatic run_rows(input aes_dec_pkg::key_t k);
        int gap;
        for (int i = 0; i < NUM_VEC; i++) begin
            if (tbl_key[i] == k) begin
                send_block(tbl_ct[i], tbl_pt[i]);
                gap = $urandom % 4;
                idle_cycles(gap);
            end
        end
        idle_cycles(1);
    endtask

    task automatic drain_pipe();
        while (vld_hist != '0) idle_cycles(1);
        idle_cycles(2);
    endtask

    initial begin
        int n;
        void'($urandom(SEED));
        rst      = 1'b0;
        key_load = 1'b0;
        key      = '0;
        in_valid = 1'b0;
        in_block = '0;

        // reset held for four rising edges
        repeat (4) begin
            @(negedge clk);
            check_bit("key_ready", key_ready, 1'b0);
        end
        rst = 1'b1;
        idle_cycles(1);
        check_bit("key_ready", key_ready, 1'b0);

        // one block with exact latency and a single valid cycle
        load_key(tbl_key[0]);
        send_block(tbl_ct[0], tbl_pt[0]);
        n = 0;
        do begin
            idle_cycles(1);
            n++;
        end while (out_valid !== 1'b1 && n < 2 * PL);
        check_count("block latency", n, PL);
        idle_cycles(1);
        check_bit("out_valid", out_valid, 1'b0);
        drain_pipe();

        // back to back blocks under the second key
        load_key(tbl_key[1]);
        for (int i = 1; i < NUM_VEC; i++) send_block(tbl_ct[i], tbl_pt[i]);
        idle_cycles(1);
        n = 0;
        while (out_valid !== 1'b1 && n < 2 * PL) begin
            idle_cycles(1);
            n++;
        end
        for (int i = 1; i < NUM_VEC - 1; i++) begin
            idle_cycles(1);
            check_bit("out_valid", out_valid, 1'b1);
        end
        idle_cycles(1);
        check_bit("out_valid", out_valid, 1'b0);
        drain_pipe();

        // random gaps under the same key
        run_rows(tbl_key[1]);
        drain_pipe();

        // reload with an empty pipeline and run both keys once more
        check_bit("key_ready", key_ready, 1'b1);
        load_key(tbl_key[0]);
        run_rows(tbl_key[0]);
        drain_pipe();
        load_key(tbl_key[1]);
        run_rows(tbl_key[1]);
        drain_pipe();

        if (dut.u_chk.fail_count != 0) begin
            fail_now("an assertion in the checker failed");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- aes_dec_pipe.f
aes_dec_pkg.sv
key_sched_if.sv
key_expander.sv
round_key_store.sv
inv_round_entry.sv
inv_round_mid.sv
inv_round_final.sv
aes_dec_pipe.sv
aes_dec_pipe_chk.sv
tb_aes_dec_pipe.sv

//--- Makefile
TOP = tb_aes_dec_pipe

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f aes_dec_pipe.f --top-module aes_dec_pipe
	verilator --lint-only --timing --assert -f aes_dec_pipe.f --top-module $(TOP)

# the binary exits non-zero on $fatal, which fails the target
sim:
	verilator --binary --timing --assert -f aes_dec_pipe.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
